// ==== verilog/cos_pkg.sv ====
// Cosine Taylor series constants
package cos_pkg;

	// Data widths
	localparam int angle_width  = 16;            // Angle input word
	localparam int result_width = 16;            // Cosine and term word
	localparam int power_width  = 18;            // Power chain word
	localparam int coeff_width  = 18;            // Series coefficient word

	// Series size
	localparam int num_terms  = 8;               // x^0 through x^14
	localparam int num_powers = 2 * (num_terms - 1);  // Highest power reached

	// Fixed shifts
	localparam int power_shift    = 17;          // After each power multiply
	localparam int angle_preshift = 2;           // Input angle to first power

	// Series coefficients, one per even power
	// Signs alternate, magnitudes are 1/(2k)! at each term's own scale
	localparam logic signed [coeff_width-1:0] coeff_table [num_terms] = '{
		18'h1_0000,                              // x^0, unity
		18'h3_0000,                              // x^2, -1/2
		18'h1_5555,                              // x^4, 1/24
		18'h2_93e9,                              // x^6, -1/720
		18'h1_a01a,                              // x^8
		18'h2_d81b,                              // x^10
		18'h1_1eee,                              // x^12
		18'h2_6c69                               // x^14
	};

	// Right shift after the coefficient multiply
	// Brings every term onto the common result scale
	localparam int term_shift_table [num_terms] = '{
		2,
		14,
		12,
		11,
		11,
		11,
		12,
		14
	};

	// Register stage counts
	localparam int power_stages = num_powers - 1;  // One per multiply, x^2 to x^14
	localparam int accum_stages = num_terms - 1;   // One per addition

endpackage

// ==== verilog/cos_input_port.sv ====
// Angle input capture
`timescale 1ns/1ps

module cos_input_port (
	input  logic                                    major_clk,
	input  logic                                    rst,
	input  logic                                    in_req,    // Four-phase request
	input  logic signed [cos_pkg::angle_width-1:0]  in_angle,
	output logic                                    in_ack,
	input  logic                                    pipe_en,   // Global stall enable
	output logic signed [cos_pkg::power_width-1:0]  x1,        // Scaled angle, stage zero
	output logic                                    x1_valid
);

	import cos_pkg::*;

	logic                          capture;   // Take the angle this cycle
	logic signed [power_width-1:0] angle_ext; // Sign extended angle

	// New request, ack still low, and room in stage zero
	assign capture = in_req && !in_ack && (!x1_valid || pipe_en);

	assign angle_ext = power_width'(in_angle);

	// Handshake and occupancy
	always_ff @(posedge major_clk) begin
		if (rst) begin
			in_ack   <= 1'b0;
			x1_valid <= 1'b0;
		end else begin
			if (capture) begin
				in_ack   <= 1'b1;
				x1_valid <= 1'b1;
			end else begin
				if (pipe_en)
					x1_valid <= 1'b0;  // Item moved into the power chain
				if (in_ack && !in_req)
					in_ack <= 1'b0;    // Request withdrawn, close the cycle
			end
		end
	end

	// Payload, exact since the shift fits the wider word
	always_ff @(posedge major_clk) begin
		if (capture)
			x1 <= angle_ext <<< angle_preshift;
	end

endmodule

// ==== verilog/power_chain.sv ====
// Pipelined chain of angle powers
`timescale 1ns/1ps

module power_chain (
	input  logic                                   major_clk,
	input  logic                                   rst,
	input  logic signed [cos_pkg::power_width-1:0] x1,
	input  logic                                   x1_valid,
	input  logic                                   pipe_en,
	// Index j holds x^(2j)
	output logic signed [cos_pkg::power_width-1:0] even_powers [1:cos_pkg::num_terms-1],
	output logic                                   powers_valid
);

	import cos_pkg::*;

	logic signed [power_width-1:0]   pwr  [2:num_powers];      // Registered x^k
	logic signed [power_width-1:0]   xf   [1:power_stages-1];  // Forwarded x1 copies
	logic signed [2*power_width-1:0] prod [1:power_stages];    // Full multiply results
	logic [power_stages:1]           vld;                      // Valid per stage

	// Stage k forms x^(k+1) from x^k and the same item's x1
	always_comb begin
		prod[1] = x1 * x1;
		for (int k = 2; k <= power_stages; k++) begin
			prod[k] = pwr[k] * xf[k-1];
		end
	end

	always_ff @(posedge major_clk) begin
		if (pipe_en) begin
			xf[1] <= x1;
			for (int k = 2; k < power_stages; k++) begin
				xf[k] <= xf[k-1];
			end
			for (int k = 1; k <= power_stages; k++) begin
				// Toward zero, so a negated angle mirrors every odd power
				if (prod[k] < 0)
					pwr[k+1] <= power_width'(-((-prod[k]) >>> power_shift));
				else
					pwr[k+1] <= power_width'(prod[k] >>> power_shift);  // Keep low word
			end
		end
	end

	// Valid travels with the chain
	always_ff @(posedge major_clk) begin
		if (rst)
			vld <= '0;
		else if (pipe_en)
			vld <= {vld[power_stages-1:1], x1_valid};
	end

	assign powers_valid = vld[power_stages];

	// Skew lines so all even powers leave with the last one
	// x^(2j) appears after stage 2j-1, so it waits num_powers-2j more
	for (genvar j = 1; j < num_terms; j++) begin : g_skew
		localparam int depth = num_powers - 2 * j;
		if (depth == 0) begin : g_direct
			assign even_powers[j] = pwr[2*j];  // Highest power, already aligned
		end else begin : g_delay
			logic signed [power_width-1:0] dly [1:depth];
			always_ff @(posedge major_clk) begin
				if (pipe_en) begin
					dly[1] <= pwr[2*j];
					for (int d = 2; d <= depth; d++) begin
						dly[d] <= dly[d-1];
					end
				end
			end
			assign even_powers[j] = dly[depth];
		end
	end

endmodule

// ==== verilog/term_multiply.sv ====
// Coefficient multiply of each even power
`timescale 1ns/1ps

module term_multiply (
	input  logic                                    major_clk,
	input  logic                                    rst,
	input  logic signed [cos_pkg::power_width-1:0]  even_powers [1:cos_pkg::num_terms-1],
	input  logic                                    powers_valid,
	input  logic                                    pipe_en,
	output logic signed [cos_pkg::result_width-1:0] terms [0:cos_pkg::num_terms-1],
	output logic                                    terms_valid
);

	import cos_pkg::*;

	// Coefficient times power, full width
	logic signed [coeff_width+power_width-1:0] prod [1:num_terms-1];

	always_comb begin
		for (int j = 1; j < num_terms; j++) begin
			prod[j] = coeff_table[j] * even_powers[j];
		end
	end

	// One register stage for all terms
	always_ff @(posedge major_clk) begin
		if (pipe_en) begin
			// Constant term, no power involved
			terms[0] <= result_width'(coeff_table[0] >>> term_shift_table[0]);
			for (int j = 1; j < num_terms; j++) begin
				// Arithmetic shift to the result scale, then drop upper bits
				terms[j] <= result_width'(prod[j] >>> term_shift_table[j]);
			end
		end
	end

	always_ff @(posedge major_clk) begin
		if (rst)
			terms_valid <= 1'b0;
		else if (pipe_en)
			terms_valid <= powers_valid;
	end

endmodule

// ==== verilog/term_accumulate.sv ====
// Pipelined running sum of terms
`timescale 1ns/1ps

module term_accumulate (
	input  logic                                    major_clk,
	input  logic                                    rst,
	input  logic signed [cos_pkg::result_width-1:0] terms [0:cos_pkg::num_terms-1],
	input  logic                                    terms_valid,
	input  logic                                    pipe_en,
	output logic signed [cos_pkg::result_width-1:0] sum,
	output logic                                    sum_valid
);

	import cos_pkg::*;

	logic signed [result_width-1:0] sum_q  [1:accum_stages];  // Partial sum per stage
	logic signed [result_width-1:0] addend [1:accum_stages];  // Term entering stage m
	logic [accum_stages:1]          vld;

	// Terms not yet added ride along, term m waits m-1 stages
	for (genvar m = 1; m <= accum_stages; m++) begin : g_carry
		if (m == 1) begin : g_now
			assign addend[m] = terms[1];
		end else begin : g_held
			logic signed [result_width-1:0] hold [1:m-1];
			always_ff @(posedge major_clk) begin
				if (pipe_en) begin
					hold[1] <= terms[m];
					for (int d = 2; d < m; d++) begin
						hold[d] <= hold[d-1];
					end
				end
			end
			assign addend[m] = hold[m-1];
		end
	end

	// Adder chain, wraps at the result width
	always_ff @(posedge major_clk) begin
		if (pipe_en) begin
			sum_q[1] <= terms[0] + addend[1];
			for (int m = 2; m <= accum_stages; m++) begin
				sum_q[m] <= sum_q[m-1] + addend[m];
			end
		end
	end

	always_ff @(posedge major_clk) begin
		if (rst)
			vld <= '0;
		else if (pipe_en)
			vld <= {vld[accum_stages-1:1], terms_valid};
	end

	assign sum       = sum_q[accum_stages];  // All terms added
	assign sum_valid = vld[accum_stages];

endmodule

// ==== verilog/cos_output_port.sv ====
// Result holding register and output handshake
`timescale 1ns/1ps

module cos_output_port (
	input  logic                                    major_clk,
	input  logic                                    rst,
	input  logic signed [cos_pkg::result_width-1:0] sum,
	input  logic                                    sum_valid,
	output logic                                    pipe_en,     // Stall for every stage
	output logic                                    out_req,     // Four-phase request
	input  logic                                    out_ack,
	output logic signed [cos_pkg::result_width-1:0] out_result
);

	import cos_pkg::*;

	logic full_q;  // Result held, not yet acknowledged
	logic load;    // Take the finished item

	// Freeze only when a finished item has nowhere to go
	assign pipe_en = !(sum_valid && full_q);
	assign load    = sum_valid && !full_q;

	always_ff @(posedge major_clk) begin
		if (rst) begin
			full_q  <= 1'b0;
			out_req <= 1'b0;
		end else begin
			if (load) begin
				full_q  <= 1'b1;
				out_req <= !out_ack;  // Previous ack must be low first
			end else if (out_req && out_ack) begin
				out_req <= 1'b0;      // Consumer has the result
				full_q  <= 1'b0;
			end else if (full_q && !out_req && !out_ack) begin
				out_req <= 1'b1;      // Delayed raise after old ack drops
			end
		end
	end

	// Stable while held
	always_ff @(posedge major_clk) begin
		if (load)
			out_result <= sum;
	end

endmodule

// ==== verilog/cos_taylor_top.sv ====
// Pipelined Taylor series cosine
`timescale 1ns/1ps

module cos_taylor_top (
	input  logic                                    major_clk,
	input  logic                                    rst,
	input  logic                                    in_req,
	input  logic signed [cos_pkg::angle_width-1:0]  in_angle,
	output logic                                    in_ack,
	output logic                                    out_req,
	input  logic                                    out_ack,
	output logic signed [cos_pkg::result_width-1:0] out_result
);

	import cos_pkg::*;

	logic                           pipe_en;                      // From output port
	logic signed [power_width-1:0]  x1;
	logic                           x1_valid;
	logic signed [power_width-1:0]  even_powers [1:num_terms-1];
	logic                           powers_valid;
	logic signed [result_width-1:0] terms [0:num_terms-1];
	logic                           terms_valid;
	logic signed [result_width-1:0] sum;
	logic                           sum_valid;

	cos_input_port u_cos_input_port (
		.major_clk (major_clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_angle  (in_angle),
		.in_ack    (in_ack),
		.pipe_en   (pipe_en),
		.x1        (x1),
		.x1_valid  (x1_valid)
	);

	power_chain u_power_chain (
		.major_clk    (major_clk),
		.rst          (rst),
		.x1           (x1),
		.x1_valid     (x1_valid),
		.pipe_en      (pipe_en),
		.even_powers  (even_powers),
		.powers_valid (powers_valid)
	);

	term_multiply u_term_multiply (
		.major_clk    (major_clk),
		.rst          (rst),
		.even_powers  (even_powers),
		.powers_valid (powers_valid),
		.pipe_en      (pipe_en),
		.terms        (terms),
		.terms_valid  (terms_valid)
	);

	term_accumulate u_term_accumulate (
		.major_clk   (major_clk),
		.rst         (rst),
		.terms       (terms),
		.terms_valid (terms_valid),
		.pipe_en     (pipe_en),
		.sum         (sum),
		.sum_valid   (sum_valid)
	);

	cos_output_port u_cos_output_port (
		.major_clk  (major_clk),
		.rst        (rst),
		.sum        (sum),
		.sum_valid  (sum_valid),
		.pipe_en    (pipe_en),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_result (out_result)
	);

endmodule

// ==== testbench/cos_ref_model.svh ====
// Cosine reference model
`ifndef COS_REF_MODEL_SVH
`define COS_REF_MODEL_SVH

localparam int cos_tolerance  = 256;                // Q1.14 LSBs allowed from the real cosine

// Low bits of a value, read back as signed
function automatic longint wrap_signed(input longint value, input int width);
	longint low;
	low = value & ((longint'(1) << width) - 1);
	if (low >= (longint'(1) << (width - 1)))
		low = low - (longint'(1) << width);  // Top bit set, negative
	return low;
endfunction

// Fixed-point series, term by term
function automatic logic signed [result_width-1:0] cos_model(
	input logic signed [angle_width-1:0] angle
);
	longint pwr [1:num_powers];
	longint term;
	logic signed [result_width-1:0] acc;
	pwr[1] = longint'(angle) <<< angle_preshift;  // Q3.12 up to the power scale
	for (int k = 2; k <= num_powers; k++) begin
		// Quotient truncated toward zero
		pwr[k] = wrap_signed((pwr[k-1] * pwr[1]) / (longint'(1) << power_shift), power_width);
	end
	acc = result_width'(longint'(coeff_table[0]) >>> term_shift_table[0]);  // Constant term
	for (int j = 1; j < num_terms; j++) begin
		term = (longint'(coeff_table[j]) * pwr[2*j]) >>> term_shift_table[j];
		acc  = acc + result_width'(term);  // 16-bit wraparound sum
	end
	return acc;
endfunction

// Distance from cos(angle) scaled by 2^14
function automatic bit near_real_cos(
	input logic signed [result_width-1:0] value,
	input logic signed [angle_width-1:0]  angle
);
	real ideal;
	real diff;
	ideal = $cos(real'(int'(angle)) / 4096.0) * 16384.0;
	diff  = real'(int'(value)) - ideal;
	return (diff <= real'(cos_tolerance)) && (diff >= -real'(cos_tolerance));
endfunction

`endif

// ==== testbench/tb_cos_taylor.sv ====
// Taylor cosine testbench
`timescale 1ns/1ps

module tb_cos_taylor;

	import cos_pkg::*;

	`include "cos_ref_model.svh"

	localparam int          clk_period    = 20;
	localparam logic [31:0] rng_seed      = 32'h1e7c;
	localparam int          pi_q312       = 12868;  // Pi in Q3.12
	localparam int          half_pi_q312  = 6434;
	localparam int          rand_count    = 40;
	localparam int          stream_count  = 60;     // Back-pressure phase
	localparam int          pair_count    = 20;
	localparam int          max_ack_delay = 7;
	localparam int          total_items   = 5 + rand_count + stream_count + 2 * pair_count;
	localparam int          pipe_depth    = power_stages + accum_stages + 3;  // Plus in, mult, hold
	localparam longint      watchdog_ns   =
		longint'(2 * total_items * (pipe_depth + max_ack_delay + 6) * clk_period);

	logic                           major_clk = 1'b0;
	logic                           rst;
	logic                           in_req;
	logic signed [angle_width-1:0]  in_angle;
	logic                           in_ack;
	logic                           out_req;
	logic                           out_ack;
	logic signed [result_width-1:0] out_result;

	logic signed [result_width-1:0] exp_mem [0:total_items];  // Model results, input order
	logic signed [result_width-1:0] got_mem [0:total_items];  // Accepted DUT results
	bit          pair_second [0:total_items];                 // Negated half of a pair
	int          wr_ptr        = 0;
	int          rd_ptr        = 0;
	logic        offered;                                     // Any request seen yet
	logic [31:0] stim_state    = rng_seed;
	logic [31:0] ack_state;
	int          ack_delay_max = 0;
	int          ack_wait;

	cos_taylor_top u_cos_taylor_top (
		.major_clk  (major_clk),
		.rst        (rst),
		.in_req     (in_req),
		.in_angle   (in_angle),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_result (out_result)
	);

	always #(clk_period / 2) major_clk = ~major_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	// Uniform in [-pi, pi]
	task automatic next_angle(output logic signed [angle_width-1:0] angle);
		stim_state = xorshift32(stim_state);
		angle = angle_width'(int'(stim_state % 32'd25737) - pi_q312);
	endtask

	// One four-phase input transaction, expected value queued on accept
	task automatic send_angle(input logic signed [angle_width-1:0] angle, input bit second);
		logic signed [result_width-1:0] model_val;
		model_val = cos_model(angle);
		assert (near_real_cos(model_val, angle))
		else stop_with_failure($sformatf("error %0t: model gives %0d for angle %0d",
			$time, model_val, angle));
		in_angle = angle;
		in_req   = 1'b1;
		@(negedge major_clk);
		while (!in_ack) @(negedge major_clk);
		exp_mem[wr_ptr]     = model_val;
		pair_second[wr_ptr] = second;
		wr_ptr              = wr_ptr + 1;
		in_req              = 1'b0;
		@(negedge major_clk);
		while (in_ack) @(negedge major_clk);  // Close the handshake
	endtask

	// Result consumer with random ack delay
	initial begin
		out_ack   = 1'b0;
		ack_state = xorshift32(rng_seed);
		ack_wait  = 0;
		forever begin
			@(negedge major_clk);
			if (out_ack) begin
				if (!out_req)
					out_ack = 1'b0;
			end else if (out_req) begin
				if (ack_wait == 0) begin
					out_ack   = 1'b1;
					ack_state = xorshift32(ack_state);
					ack_wait  = int'(ack_state % 32'(ack_delay_max + 1));
				end else begin
					ack_wait = ack_wait - 1;
				end
			end
		end
	end

	// Scoreboard pointer and record of results
	always @(posedge major_clk) begin
		if (!rst && out_req && out_ack) begin
			got_mem[rd_ptr] <= out_result;
			rd_ptr          <= rd_ptr + 1;
		end
	end

	always @(posedge major_clk) begin
		if (rst)
			offered <= 1'b0;
		else if (in_req)
			offered <= 1'b1;
	end

	a_reset_quiet: assert property (@(posedge major_clk) rst |=> !in_ack && !out_req)
		else stop_with_failure($sformatf("error %0t: handshake outputs high after reset", $time));

	a_no_early_result: assert property (@(posedge major_clk) disable iff (rst)
		!offered |-> !out_req)
		else stop_with_failure($sformatf("error %0t: out_req before any input", $time));

	// Order, value, and no result beyond the accepted inputs
	a_result_exact: assert property (@(posedge major_clk) disable iff (rst)
		out_req |-> (rd_ptr < wr_ptr) && (out_result == exp_mem[rd_ptr]))
		else stop_with_failure($sformatf("error %0t: result %0d, expected %0d (item %0d of %0d)",
			$time, out_result, exp_mem[rd_ptr], rd_ptr, wr_ptr));

	a_result_hold: assert property (@(posedge major_clk) disable iff (rst)
		out_req && !out_ack |=> out_req && $stable(out_result))
		else stop_with_failure($sformatf("error %0t: output changed before out_ack", $time));

	a_req_after_ack_low: assert property (@(posedge major_clk) disable iff (rst)
		$rose(out_req) |-> !$past(out_ack))
		else stop_with_failure($sformatf("error %0t: out_req rose with out_ack high", $time));

	a_in_ack_rise: assert property (@(posedge major_clk) disable iff (rst)
		$rose(in_ack) |-> $past(in_req))
		else stop_with_failure($sformatf("error %0t: in_ack rose without in_req", $time));

	a_in_ack_fall: assert property (@(posedge major_clk) disable iff (rst)
		$fell(in_ack) |-> !$past(in_req))
		else stop_with_failure($sformatf("error %0t: in_ack fell with in_req high", $time));

	// Only even powers reach the terms, so -a returns exactly the result for a
	a_pair_match: assert property (@(posedge major_clk) disable iff (rst)
		out_req && pair_second[rd_ptr] |-> out_result == got_mem[rd_ptr-1])
		else stop_with_failure($sformatf("error %0t: pair results %0d and %0d differ",
			$time, got_mem[rd_ptr-1], out_result));

	initial begin
		#(watchdog_ns);
		stop_with_failure("timeout: the DUT did not return every result in time");
	end

	initial begin : stimulus
		logic signed [angle_width-1:0] angle;
		int                            gap;
		rst      = 1'b1;
		in_req   = 1'b0;
		in_angle = '0;
		repeat (3) @(negedge major_clk);
		rst = 1'b0;
		repeat (4) @(negedge major_clk);  // Idle, nothing offered
		send_angle(angle_width'(0), 1'b0);
		send_angle(angle_width'(half_pi_q312), 1'b0);
		send_angle(angle_width'(-half_pi_q312), 1'b0);
		send_angle(angle_width'(pi_q312), 1'b0);
		send_angle(angle_width'(-pi_q312), 1'b0);
		for (int i = 0; i < rand_count; i++) begin
			next_angle(angle);
			send_angle(angle, 1'b0);
		end
		ack_delay_max = max_ack_delay;  // Slow consumer, pipeline stalls
		for (int i = 0; i < stream_count; i++) begin
			next_angle(angle);
			send_angle(angle, 1'b0);
			stim_state = xorshift32(stim_state);
			gap = int'(stim_state % 32'd3);
			repeat (gap) @(negedge major_clk);
		end
		ack_delay_max = 3;
		for (int i = 0; i < pair_count; i++) begin
			next_angle(angle);
			send_angle(angle, 1'b0);
			send_angle(-angle, 1'b1);
		end
		while (rd_ptr != wr_ptr) @(negedge major_clk);  // Drain
		repeat (pipe_depth) @(negedge major_clk);
		if (rd_ptr == wr_ptr && !out_req) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_with_failure("more results came back than inputs were accepted");
		end
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
verilog/cos_pkg.sv
verilog/cos_input_port.sv
verilog/power_chain.sv
verilog/term_multiply.sv
verilog/term_accumulate.sv
verilog/cos_output_port.sv
verilog/cos_taylor_top.sv
testbench/tb_cos_taylor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_cos_taylor -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_cos_taylor 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
echo "pass line not found"
exit 1
